//--- hw/exu_settings.svh
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// datapath width for operands, addresses and results
`define EXU_XLEN 32

// data memory depth as log2 of the number of words
`define EXU_DMEM_ADDR_BITS 8

`define EXU_DMEM_WORDS (1 << `EXU_DMEM_ADDR_BITS)

`endif

//--- hw/exu_pkg.sv
package exu_pkg;

	typedef enum logic [6:0] {
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		BRANCH = 7'b1100011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		OP_IMM = 7'b0010011,
		OP     = 7'b0110011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B,
		ALU_LINK    // pc + 4
	} alu_op_e;

	// nine conditions need four bits
	typedef enum logic [3:0] {
		BR_NONE,
		BR_EQ,
		BR_NE,
		BR_LT,
		BR_GE,
		BR_LTU,
		BR_GEU,
		BR_JAL,
		BR_JALR
	} br_cond_e;

	typedef enum logic [3:0] {
		MEM_NONE,
		MEM_LB,
		MEM_LH,
		MEM_LW,
		MEM_LBU,
		MEM_LHU,
		MEM_SB,
		MEM_SH,
		MEM_SW
	} mem_kind_e;

endpackage

//--- hw/exu_decode.sv
`timescale 1ns/100ps

module exu_decode import exu_pkg::*; (
	input  logic [6:0] opcode,
	input  logic [2:0] funct3,
	input  logic [6:0] funct7,
	output alu_op_e    alu_op,
	output logic       a_is_pc,
	output logic       b_is_imm,
	output br_cond_e   br_cond,
	output mem_kind_e  mem_kind,
	output logic       writes_val
);

	opcode_e op;

	assign op = opcode_e'(opcode);

	always_comb begin
		alu_op = ALU_ADD;
		a_is_pc = 1'b0;
		b_is_imm = 1'b0;
		br_cond = BR_NONE;
		mem_kind = MEM_NONE;
		writes_val = 1'b0;
		case (op)
		LUI: begin
			alu_op = ALU_PASS_B;
			b_is_imm = 1'b1;
			writes_val = 1'b1;
		end
		AUIPC: begin
			a_is_pc = 1'b1;
			b_is_imm = 1'b1;
			writes_val = 1'b1;
		end
		JAL: begin
			alu_op = ALU_LINK;
			br_cond = BR_JAL;
			writes_val = 1'b1;
		end
		JALR: begin
			if (funct3 == 3'b000) begin
				alu_op = ALU_LINK;
				br_cond = BR_JALR;
				writes_val = 1'b1;
			end
		end
		BRANCH: begin
			case (funct3)
			3'b000: br_cond = BR_EQ;
			3'b001: br_cond = BR_NE;
			3'b100: br_cond = BR_LT;
			3'b101: br_cond = BR_GE;
			3'b110: br_cond = BR_LTU;
			3'b111: br_cond = BR_GEU;
			default: br_cond = BR_NONE;
			endcase
		end
		LOAD: begin
			b_is_imm = 1'b1;    // address = src1 + imm
			writes_val = 1'b1;
			case (funct3)
			3'b000: mem_kind = MEM_LB;
			3'b001: mem_kind = MEM_LH;
			3'b010: mem_kind = MEM_LW;
			3'b100: mem_kind = MEM_LBU;
			3'b101: mem_kind = MEM_LHU;
			default: writes_val = 1'b0;
			endcase
		end
		STORE: begin
			b_is_imm = 1'b1;
			case (funct3)
			3'b000: mem_kind = MEM_SB;
			3'b001: mem_kind = MEM_SH;
			3'b010: mem_kind = MEM_SW;
			default: mem_kind = MEM_NONE;
			endcase
		end
		OP_IMM: begin
			b_is_imm = 1'b1;
			writes_val = 1'b1;
			case (funct3)
			3'b000: alu_op = ALU_ADD;
			3'b010: alu_op = ALU_SLT;
			3'b011: alu_op = ALU_SLTU;
			3'b100: alu_op = ALU_XOR;
			3'b110: alu_op = ALU_OR;
			3'b111: alu_op = ALU_AND;
			3'b001: begin
				if (funct7 == 7'b0000000)
					alu_op = ALU_SLL;
				else
					writes_val = 1'b0;
			end
			default: begin    // srli / srai
				if (funct7 == 7'b0000000)
					alu_op = ALU_SRL;
				else if (funct7 == 7'b0100000)
					alu_op = ALU_SRA;
				else
					writes_val = 1'b0;
			end
			endcase
		end
		OP: begin
			writes_val = 1'b1;
			case ({funct7, funct3})
			10'b0000000_000: alu_op = ALU_ADD;
			10'b0100000_000: alu_op = ALU_SUB;
			10'b0000000_001: alu_op = ALU_SLL;
			10'b0000000_010: alu_op = ALU_SLT;
			10'b0000000_011: alu_op = ALU_SLTU;
			10'b0000000_100: alu_op = ALU_XOR;
			10'b0000000_101: alu_op = ALU_SRL;
			10'b0100000_101: alu_op = ALU_SRA;
			10'b0000000_110: alu_op = ALU_OR;
			10'b0000000_111: alu_op = ALU_AND;
			default: writes_val = 1'b0;
			endcase
		end
		default: ;    // fence, system and anything else
		endcase
	end

endmodule

//--- hw/exu_alu.sv
`timescale 1ns/100ps

`include "exu_settings.svh"

module exu_alu import exu_pkg::*; (
	input  alu_op_e                alu_op,
	input  logic                   a_is_pc,
	input  logic                   b_is_imm,
	input  logic [`EXU_XLEN-1:0]   src1,
	input  logic [`EXU_XLEN-1:0]   src2,
	input  logic [`EXU_XLEN-1:0]   imm,
	input  logic [`EXU_XLEN-1:0]   pc,
	output logic [`EXU_XLEN-1:0]   alu_result
);

	logic [`EXU_XLEN-1:0] op_a;
	logic [`EXU_XLEN-1:0] op_b;
	logic [4:0]           shamt;
	logic                 lt_signed;
	logic                 lt_unsigned;

	assign op_a = a_is_pc ? pc : src1;
	assign op_b = b_is_imm ? imm : src2;
	assign shamt = op_b[4:0];    // srai imm carries funct7 above this

	assign lt_signed = $signed(op_a) < $signed(op_b);
	assign lt_unsigned = op_a < op_b;

	always_comb begin
		case (alu_op)
		ALU_ADD: begin
			alu_result = op_a + op_b;
		end
		ALU_SUB: begin
			alu_result = op_a - op_b;
		end
		ALU_SLL: begin
			alu_result = op_a << shamt;
		end
		ALU_SLT: begin
			alu_result = {{(`EXU_XLEN-1){1'b0}}, lt_signed};
		end
		ALU_SLTU: begin
			alu_result = {{(`EXU_XLEN-1){1'b0}}, lt_unsigned};
		end
		ALU_XOR: begin
			alu_result = op_a ^ op_b;
		end
		ALU_SRL: begin
			alu_result = op_a >> shamt;
		end
		ALU_SRA: begin
			alu_result = $unsigned($signed(op_a) >>> shamt);
		end
		ALU_OR: begin
			alu_result = op_a | op_b;
		end
		ALU_AND: begin
			alu_result = op_a & op_b;
		end
		ALU_PASS_B: begin
			alu_result = op_b;    // lui
		end
		ALU_LINK: begin
			alu_result = pc + `EXU_XLEN'd4;
		end
		default: begin
			alu_result = '0;
		end
		endcase
	end

endmodule

//--- hw/exu_branch.sv
`timescale 1ns/100ps

`include "exu_settings.svh"

module exu_branch import exu_pkg::*; (
	input  br_cond_e               br_cond,
	input  logic [`EXU_XLEN-1:0]   src1,
	input  logic [`EXU_XLEN-1:0]   src2,
	input  logic [`EXU_XLEN-1:0]   imm,
	input  logic [`EXU_XLEN-1:0]   pc,
	output logic [`EXU_XLEN-1:0]   target
);

	logic                 eq;
	logic                 lt_s;
	logic                 lt_u;
	logic                 taken;
	logic [`EXU_XLEN-1:0] pc_rel;
	logic [`EXU_XLEN-1:0] reg_rel;

	assign eq = src1 == src2;
	assign lt_s = $signed(src1) < $signed(src2);
	assign lt_u = src1 < src2;

	assign pc_rel = pc + imm;
	assign reg_rel = src1 + imm;

	always_comb begin
		case (br_cond)
		BR_EQ:   taken = eq;
		BR_NE:   taken = !eq;
		BR_LT:   taken = lt_s;
		BR_GE:   taken = !lt_s;
		BR_LTU:  taken = lt_u;
		BR_GEU:  taken = !lt_u;
		BR_JAL:  taken = 1'b1;
		BR_JALR: taken = 1'b1;
		default: taken = 1'b0;
		endcase
	end

	always_comb begin
		if (!taken)
			target = '0;    // zero means fall through
		else if (br_cond == BR_JALR)
			target = {reg_rel[`EXU_XLEN-1:1], 1'b0};
		else
			target = pc_rel;
	end

endmodule

//--- hw/exu_commit.sv
`timescale 1ns/100ps

`include "exu_settings.svh"

module exu_commit import exu_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   issue,
	input  logic                   writes_val,
	input  mem_kind_e              mem_kind,
	input  logic [`EXU_XLEN-1:0]   alu_result,
	input  logic [`EXU_XLEN-1:0]   target,
	input  logic [`EXU_XLEN-1:0]   store_data,
	output logic                   done,
	output logic [`EXU_XLEN-1:0]   val,
	output logic [`EXU_XLEN-1:0]   jump
);

	logic [`EXU_XLEN-1:0]           mem [`EXU_DMEM_WORDS];
	logic [`EXU_DMEM_ADDR_BITS-1:0] word_idx;
	logic [1:0]                     byte_off;
	logic [`EXU_XLEN-1:0]           rdata;
	logic [`EXU_XLEN-1:0]           wdata;
	logic [3:0]                     byte_en;
	logic [7:0]                     rd_byte;
	logic [15:0]                    rd_half;
	logic [`EXU_XLEN-1:0]           load_val;
	logic                           is_load;
	logic                           do_issue;

	assign word_idx = alu_result[`EXU_DMEM_ADDR_BITS+1:2];
	assign byte_off = alu_result[1:0];
	assign do_issue = issue && !rst;

	assign rdata = mem[word_idx];    // async read
	assign rd_byte = rdata[8*byte_off +: 8];
	assign rd_half = byte_off[1] ? rdata[31:16] : rdata[15:0];

	always_comb begin
		byte_en = 4'b0000;
		wdata = store_data;
		case (mem_kind)
		MEM_SB: begin
			byte_en = 4'b0001 << byte_off;
			wdata = {4{store_data[7:0]}};
		end
		MEM_SH: begin
			byte_en = byte_off[1] ? 4'b1100 : 4'b0011;    // bit 0 ignored
			wdata = {2{store_data[15:0]}};
		end
		MEM_SW: byte_en = 4'b1111;
		default: ;
		endcase
	end

	always_comb begin
		is_load = 1'b1;
		case (mem_kind)
		MEM_LB:  load_val = {{24{rd_byte[7]}}, rd_byte};
		MEM_LBU: load_val = {24'b0, rd_byte};
		MEM_LH:  load_val = {{16{rd_half[15]}}, rd_half};
		MEM_LHU: load_val = {16'b0, rd_half};
		MEM_LW:  load_val = rdata;
		default: begin
			is_load = 1'b0;
			load_val = '0;
		end
		endcase
	end

	always_ff @(posedge clk) begin
		if (do_issue) begin
			for (int i = 0; i < 4; i++) begin
				if (byte_en[i])
					mem[word_idx][8*i +: 8] <= wdata[8*i +: 8];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			done <= 1'b0;
			val <= '0;
			jump <= '0;
		end else begin
			done <= issue;
			if (issue) begin
				jump <= target;
				if (is_load)
					val <= load_val;
				else if (writes_val)
					val <= alu_result;
				else
					val <= '0;    // stores, branches, unknown
			end
		end
	end

endmodule

//--- hw/exu_top.sv
`timescale 1ns/100ps

`include "exu_settings.svh"

module exu_top import exu_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   issue,
	input  logic [6:0]             opcode,
	input  logic [2:0]             funct3,
	input  logic [6:0]             funct7,
	input  logic [`EXU_XLEN-1:0]   src1,
	input  logic [`EXU_XLEN-1:0]   src2,
	input  logic [`EXU_XLEN-1:0]   imm,
	input  logic [`EXU_XLEN-1:0]   pc,
	output logic                   done,
	output logic [`EXU_XLEN-1:0]   val,
	output logic [`EXU_XLEN-1:0]   jump
);

	alu_op_e              alu_op;
	br_cond_e             br_cond;
	mem_kind_e            mem_kind;
	logic                 a_is_pc;
	logic                 b_is_imm;
	logic                 writes_val;
	logic [`EXU_XLEN-1:0] alu_result;
	logic [`EXU_XLEN-1:0] target;

	exu_decode u_decode (
		.opcode     (opcode),
		.funct3     (funct3),
		.funct7     (funct7),
		.alu_op     (alu_op),
		.a_is_pc    (a_is_pc),
		.b_is_imm   (b_is_imm),
		.br_cond    (br_cond),
		.mem_kind   (mem_kind),
		.writes_val (writes_val)
	);

	exu_alu u_alu (
		.alu_op     (alu_op),
		.a_is_pc    (a_is_pc),
		.b_is_imm   (b_is_imm),
		.src1       (src1),
		.src2       (src2),
		.imm        (imm),
		.pc         (pc),
		.alu_result (alu_result)
	);

	exu_branch u_branch (
		.br_cond (br_cond),
		.src1    (src1),
		.src2    (src2),
		.imm     (imm),
		.pc      (pc),
		.target  (target)
	);

	exu_commit u_commit (
		.clk        (clk),
		.rst        (rst),
		.issue      (issue),
		.writes_val (writes_val),
		.mem_kind   (mem_kind),
		.alu_result (alu_result),
		.target     (target),
		.store_data (src2),    // rs2 carries store data
		.done       (done),
		.val        (val),
		.jump       (jump)
	);

endmodule

//--- verification/exu_checker.sv
`timescale 1ns/100ps

`include "exu_settings.svh"

module exu_checker import exu_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 issue,
	input  logic [6:0]           opcode,
	input  logic [2:0]           funct3,
	input  logic [6:0]           funct7,
	input  logic [`EXU_XLEN-1:0] src1,
	input  logic [`EXU_XLEN-1:0] src2,
	input  logic [`EXU_XLEN-1:0] imm,
	input  logic [`EXU_XLEN-1:0] pc,
	input  logic                 done,
	input  logic [`EXU_XLEN-1:0] val,
	input  logic [`EXU_XLEN-1:0] jump,
	output int                   mismatches,
	output int                   protocol_errs
);

	localparam int MEM_BYTES = 4 * `EXU_DMEM_WORDS;

	logic [7:0]             mem_model [MEM_BYTES];    // byte addressed
	logic                   pending = 1'b0;
	logic [`EXU_XLEN-1:0]   exp_val = '0;
	logic [`EXU_XLEN-1:0]   exp_jump = '0;
	logic [2*`EXU_XLEN-1:0] res;

	// returns {val, jump} as the architecture defines them
	function automatic logic [2*`EXU_XLEN-1:0] ref_result(input logic [6:0] op,
			input logic [2:0] f3, input logic [6:0] f7, input logic [`EXU_XLEN-1:0] a,
			input logic [`EXU_XLEN-1:0] b, input logic [`EXU_XLEN-1:0] im,
			input logic [`EXU_XLEN-1:0] p);
		logic [`EXU_XLEN-1:0] v;
		logic [`EXU_XLEN-1:0] j;
		logic [`EXU_XLEN-1:0] addr;
		logic [`EXU_XLEN-1:0] ob;
		logic [4:0]           sh;
		logic                 take;
		logic                 ok;
		int                   bi;
		int                   hi;
		int                   wi;
		v = '0;
		j = '0;
		take = 1'b0;
		addr = a + im;
		bi = addr[`EXU_DMEM_ADDR_BITS+1:0];
		hi = bi & ~1;    // halfword ignores bit 0
		wi = bi & ~3;
		case (op)
		LUI:   v = im;
		AUIPC: v = p + im;
		JAL: begin
			v = p + 4;
			j = p + im;
		end
		JALR: begin
			if (f3 == 3'd0) begin
				v = p + 4;
				j = (a + im) & ~`EXU_XLEN'd1;
			end
		end
		BRANCH: begin
			case (f3)
			3'd0: take = a == b;
			3'd1: take = a != b;
			3'd4: take = $signed(a) < $signed(b);
			3'd5: take = $signed(a) >= $signed(b);
			3'd6: take = a < b;
			3'd7: take = a >= b;
			default: take = 1'b0;
			endcase
			if (take)
				j = p + im;
		end
		LOAD: begin
			case (f3)
			3'd0: v = {{24{mem_model[bi][7]}}, mem_model[bi]};
			3'd1: v = {{16{mem_model[hi+1][7]}}, mem_model[hi+1], mem_model[hi]};
			3'd2: v = {mem_model[wi+3], mem_model[wi+2], mem_model[wi+1], mem_model[wi]};
			3'd4: v = {24'd0, mem_model[bi]};
			3'd5: v = {16'd0, mem_model[hi+1], mem_model[hi]};
			default: v = '0;
			endcase
		end
		OP_IMM, OP: begin
			ob = (op == OP_IMM) ? im : b;
			sh = ob[4:0];
			ok = (f7 == 7'h00) ||
				(f7 == 7'h20 && (f3 == 3'd5 || (f3 == 3'd0 && op == OP)));
			if (op == OP_IMM && f3 != 3'd1 && f3 != 3'd5)
				ok = 1'b1;    // funct7 is part of the immediate here
			if (ok) begin
				case (f3)
				3'd0: v = (op == OP && f7[5]) ? a - ob : a + ob;
				3'd1: v = a << sh;
				3'd2: v = {31'd0, $signed(a) < $signed(ob)};
				3'd3: v = {31'd0, a < ob};
				3'd4: v = a ^ ob;
				3'd5: begin
					if (f7[5])    // fill the vacated top bits with the sign
						v = (a >> sh) |
							({`EXU_XLEN{a[`EXU_XLEN-1]}} & ~({`EXU_XLEN{1'b1}} >> sh));
					else
						v = a >> sh;
				end
				3'd6: v = a | ob;
				default: v = a & ob;
				endcase
			end
		end
		default: ;    // stores and unknown encodings
		endcase
		return {v, j};
	endfunction

	task automatic apply_store(input logic [2:0] f3, input logic [`EXU_XLEN-1:0] addr,
			input logic [`EXU_XLEN-1:0] data);
		int bi;
		int k;
		bi = addr[`EXU_DMEM_ADDR_BITS+1:0];
		case (f3)
		3'd0: mem_model[bi] = data[7:0];
		3'd1: begin
			bi = bi & ~1;
			mem_model[bi] = data[7:0];
			mem_model[bi+1] = data[15:8];
		end
		3'd2: begin
			bi = bi & ~3;
			for (k = 0; k < 4; k++)
				mem_model[bi+k] = data[8*k +: 8];
		end
		default: ;    // invalid width writes nothing
		endcase
	endtask

	task automatic report_mismatch(input string name, input logic [`EXU_XLEN-1:0] expected,
			input logic [`EXU_XLEN-1:0] got);
		mismatches++;
		$display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, got);
	endtask

	initial begin
		mismatches = 0;
		protocol_errs = 0;
	end

	always @(posedge clk) begin
		if (rst) begin
			pending = 1'b0;
			exp_val = '0;    // outputs come out of reset as zero
			exp_jump = '0;
		end else begin
			if (pending) begin
				if (done !== 1'b1) begin
					protocol_errs++;
					$display("%0t: an issued instruction got no done one cycle later", $time);
				end else begin
					if (val !== exp_val)
						report_mismatch("val", exp_val, val);
					if (jump !== exp_jump)
						report_mismatch("jump", exp_jump, jump);
				end
			end else begin
				if (done !== 1'b0) begin
					protocol_errs++;
					$display("%0t: done went high without an outstanding issue", $time);
				end
				// idle cycle, outputs hold the last result
				if (val !== exp_val)
					report_mismatch("val", exp_val, val);
				if (jump !== exp_jump)
					report_mismatch("jump", exp_jump, jump);
			end
			pending = issue;
			if (issue) begin
				res = ref_result(opcode, funct3, funct7, src1, src2, imm, pc);
				exp_val = res[2*`EXU_XLEN-1:`EXU_XLEN];
				exp_jump = res[`EXU_XLEN-1:0];
				if (opcode == STORE)
					apply_store(funct3, src1 + imm, src2);
			end
		end
	end

endmodule

//--- verification/exu_tb.sv
`timescale 1ns/100ps

`include "exu_settings.svh"

module exu_tb import exu_pkg::*; ();

	localparam int N_ALU = 200;
	localparam int N_JMP = 20;
	localparam int N_BR = 60;    // 5 pairs, both orders, 6 conditions
	localparam int N_MEM = 150;
	localparam int N_UNK = 12;
	localparam int N_TOTAL = `EXU_DMEM_WORDS + 2*N_ALU + 4*N_JMP + N_BR + 2*N_MEM + 2*N_UNK;
	localparam int TIMEOUT_CYCLES = N_TOTAL + 50;
	localparam logic [`EXU_XLEN-1:0] MEM_MASK = 4 * `EXU_DMEM_WORDS - 1;

	logic                 clk;
	logic                 rst;
	logic                 issue;
	logic [6:0]           opcode;
	logic [2:0]           funct3;
	logic [6:0]           funct7;
	logic [`EXU_XLEN-1:0] src1;
	logic [`EXU_XLEN-1:0] src2;
	logic [`EXU_XLEN-1:0] imm;
	logic [`EXU_XLEN-1:0] pc;
	logic                 done;
	logic [`EXU_XLEN-1:0] val;
	logic [`EXU_XLEN-1:0] jump;
	int                   mismatches;
	int                   protocol_errs;
	int                   seed = 72;
	int                   cycles = 0;

	logic [`EXU_XLEN-1:0] br_a [5] = '{32'h1234_5678, 32'h7fff_ffff, 32'h0000_0000,
		32'hffff_ffff, 32'h8000_0000};
	logic [`EXU_XLEN-1:0] br_b [5] = '{32'h1234_5678, 32'h8000_0000, 32'hffff_ffff,
		32'h0000_0001, 32'h8000_0000};
	logic [2:0]           br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
	logic [2:0]           ld_f3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};

	exu_top DUT (
		.clk    (clk),
		.rst    (rst),
		.issue  (issue),
		.opcode (opcode),
		.funct3 (funct3),
		.funct7 (funct7),
		.src1   (src1),
		.src2   (src2),
		.imm    (imm),
		.pc     (pc),
		.done   (done),
		.val    (val),
		.jump   (jump)
	);

	exu_checker u_checker (
		.clk           (clk),
		.rst           (rst),
		.issue         (issue),
		.opcode        (opcode),
		.funct3        (funct3),
		.funct7        (funct7),
		.src1          (src1),
		.src2          (src2),
		.imm           (imm),
		.pc            (pc),
		.done          (done),
		.val           (val),
		.jump          (jump),
		.mismatches    (mismatches),
		.protocol_errs (protocol_errs)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the stimulus did not complete", cycles);
			$display("Errors: %0d mismatches, %0d protocol", mismatches, protocol_errs);
			$display("Test failed");
			$finish;
		end
	end

	function automatic logic [`EXU_XLEN-1:0] rnd();
		return $random(seed);
	endfunction

	function automatic logic [`EXU_XLEN-1:0] rnd_pc();
		logic [`EXU_XLEN-1:0] r;
		r = $random(seed);
		return {r[`EXU_XLEN-1:2], 2'b00};
	endfunction

	function automatic logic [`EXU_XLEN-1:0] sext12(input logic [11:0] x);
		return {{(`EXU_XLEN-12){x[11]}}, x};
	endfunction

	task automatic send(input logic [6:0] op, input logic [2:0] f3, input logic [6:0] f7,
			input logic [`EXU_XLEN-1:0] s1, input logic [`EXU_XLEN-1:0] s2,
			input logic [`EXU_XLEN-1:0] im, input logic [`EXU_XLEN-1:0] p);
		@(posedge clk);
		issue <= 1'b1;
		opcode <= op;
		funct3 <= f3;
		funct7 <= f7;
		src1 <= s1;
		src2 <= s2;
		imm <= im;
		pc <= p;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			issue <= 1'b0;
		end
	endtask

	initial begin
		int                   i;
		int                   k;
		int                   o;
		logic [2:0]           f3;
		logic [6:0]           f7;
		logic [`EXU_XLEN-1:0] r;
		logic [`EXU_XLEN-1:0] a;
		logic [`EXU_XLEN-1:0] b;
		logic [`EXU_XLEN-1:0] im;
		logic [`EXU_XLEN-1:0] addr;
		clk = 1'b0;
		rst = 1'b1;
		issue = 1'b0;
		opcode = '0;
		funct3 = '0;
		funct7 = '0;
		src1 = '0;
		src2 = '0;
		imm = '0;
		pc = '0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		idle(4);    // outputs must stay at reset values

		for (i = 0; i < `EXU_DMEM_WORDS; i++)
			send(STORE, 3'd2, 7'd0, i * 4, rnd(), '0, rnd_pc());    // fill every word
		idle(1);

		for (i = 0; i < N_ALU; i++) begin
			f3 = rnd();
			r = rnd();
			f7 = ((f3 == 3'd0 || f3 == 3'd5) && r[0]) ? 7'h20 : 7'h00;
			send(OP, f3, f7, rnd(), rnd(), rnd(), rnd_pc());
			f3 = rnd();
			r = rnd();
			f7 = (f3 == 3'd5 && r[0]) ? 7'h20 : 7'h00;
			if (f3 == 3'd1 || f3 == 3'd5)
				im = {20'd0, f7, r[5:1]};    // shamt form
			else
				im = sext12(r[12:1]);
			send(OP_IMM, f3, f7, rnd(), rnd(), im, rnd_pc());
		end
		idle(1);

		for (i = 0; i < N_JMP; i++) begin
			r = rnd();
			send(LUI, 3'd0, 7'd0, rnd(), rnd(), {r[31:12], 12'd0}, rnd_pc());
			r = rnd();
			send(AUIPC, 3'd0, 7'd0, rnd(), rnd(), {r[31:12], 12'd0}, rnd_pc());
			r = rnd();
			send(JAL, 3'd0, 7'd0, rnd(), rnd(), {{11{r[20]}}, r[20:1], 1'b0}, rnd_pc());
			r = rnd();
			send(JALR, 3'd0, 7'd0, rnd(), rnd(), sext12(r[11:0]), rnd_pc());
		end
		idle(1);

		for (i = 0; i < 10; i++) begin
			a = (i < 5) ? br_a[i % 5] : br_b[i % 5];
			b = (i < 5) ? br_b[i % 5] : br_a[i % 5];
			for (k = 0; k < 6; k++) begin
				r = rnd();
				im = {{19{r[12]}}, r[12:1], 1'b0};
				send(BRANCH, br_f3[k], 7'd0, a, b, im, rnd_pc());
			end
		end
		idle(1);

		for (i = 0; i < N_MEM; i++) begin
			r = rnd();
			addr = r & MEM_MASK;
			im = sext12(r[31:20]);
			a = addr - im;
			o = rnd() % 3;
			send(STORE, o, 7'd0, a, rnd(), im, rnd_pc());
			o = rnd() % 5;
			send(LOAD, ld_f3[o], 7'd0, a, rnd(), im, rnd_pc());
		end
		idle(1);

		for (i = 0; i < N_UNK; i++) begin
			r = rnd();
			addr = r & MEM_MASK;
			im = sext12(r[31:20]);
			a = addr - im;
			case (i % 4)
			0: send(7'b0001111, 3'd0, 7'd0, a, rnd(), im, rnd_pc());    // fence
			1: send(7'b1110011, 3'd0, 7'd0, a, rnd(), im, rnd_pc());    // system
			2: send(STORE, 3'd3, 7'd0, a, rnd(), im, rnd_pc());
			default: send(7'b1111111, 3'd0, 7'd0, a, rnd(), im, rnd_pc());
			endcase
			send(LOAD, 3'd2, 7'd0, a, rnd(), im, rnd_pc());    // word must be unchanged
		end

		idle(3);
		@(negedge clk);
		$display("Errors: %0d mismatches, %0d protocol", mismatches, protocol_errs);
		if (mismatches == 0 && protocol_errs == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+hw
hw/exu_pkg.sv
hw/exu_decode.sv
hw/exu_alu.sv
hw/exu_branch.sv
hw/exu_commit.sv
hw/exu_top.sv
verification/exu_checker.sv
verification/exu_tb.sv
